/* common/softusb_bus_pkg.sv */
/*
 * Memory bus definitions.
 * Data, address and byte select widths.
 * Address region encoding of the top two address bits.
 * Default RAM depth.
 */
package softusb_bus_pkg;

	localparam int DATA_W = 32; // Bus data width.
	localparam int ADDR_W = 32; // Bus address width.
	localparam int SEL_W = DATA_W / 8; // One select bit per byte.

	// Region from address bits 31:30.
	typedef enum logic [1:0] {
		REG_RAM    = 2'b00, // Program/data RAM.
		REG_TIMER  = 2'b01, // Free-running tick counter.
		REG_HOSTIF = 2'b10, // Host mailbox.
		REG_PORTS  = 2'b11  // USB port bank.
	} region_e;

	localparam int RAM_WORDS_DEF = 1024; // Default RAM depth in words.

endpackage

/* common/softusb_port_pkg.sv */
/*
 * USB port definitions.
 * Port register map and line-state encoding.
 * Default port count, port index position and width helper.
 */
package softusb_port_pkg;

	// Port register from address bits 3:2.
	typedef enum logic [1:0] {
		PR_CTRL  = 2'b00, // Speed and output enable.
		PR_TX    = 2'b01, // Transmit line state.
		PR_RX    = 2'b10, // Synchronized receive lines.
		PR_EVENT = 2'b11  // Line-change flag, clear on read.
	} port_reg_e;

	// Line states. Bit 0 is vp, bit 1 is vm.
	typedef enum logic [1:0] {
		LS_SE0 = 2'b00,
		LS_J   = 2'b01,
		LS_K   = 2'b10,
		LS_SE1 = 2'b11
	} line_e;

	localparam int NUM_PORTS_DEF = 2; // Default number of ports.
	localparam int PORT_IDX_BIT = 4; // Low bit of the port index.

	// Port index width, at least one bit.
	function automatic int idx_w(input int n);
		return (n > 1) ? $clog2(n) : 1;
	endfunction

endpackage

/* common/softusb_mem_if.sv */
/*
 * Bus slice toward one slave.
 * Master, slave and read-back monitor modports.
 */
`timescale 1ns/100ps

interface softusb_mem_if import softusb_bus_pkg::*; ();

	logic              we;    // Gated write, first request cycle only.
	logic              re;    // Gated read, first request cycle only.
	logic [SEL_W-1:0]  sel;   // Byte select.
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	logic [DATA_W-1:0] rdata; // Valid in the done cycle.

	// Decoder side.
	modport master (
		output we, re, sel, addr, wdata,
		input  rdata
	);

	// Slave side.
	modport slave (
		input  we, re, sel, addr, wdata,
		output rdata
	);

	// Read mux only looks at the data.
	modport monitor (
		input rdata
	);

endinterface

/* hdl/softusb_decoder.sv */
/*
 * Address decoder.
 * Region and port select, per-slave strobe gating.
 * One-cycle acknowledge, registered region and port index for read-back.
 */
`timescale 1ns/100ps

module softusb_decoder import softusb_bus_pkg::*, softusb_port_pkg::*; #(
	parameter int NUM_PORTS = NUM_PORTS_DEF,
	localparam int PIDX_W = idx_w(NUM_PORTS)
) (
	input  logic              usb_clk,
	input  logic              usb_rst,
	input  logic              re_i,
	input  logic              we_i,
	input  logic [ADDR_W-1:0] addr_i,
	input  logic [SEL_W-1:0]  sel_i,
	input  logic [DATA_W-1:0] wdata_i,
	output logic              done_o,
	output region_e           region_o,
	output logic [PIDX_W-1:0] port_idx_o,
	softusb_mem_if.master     ram_m,
	softusb_mem_if.master     timer_m,
	softusb_mem_if.master     hostif_m,
	softusb_mem_if.master     ports_m [NUM_PORTS]
);

	region_e           region;
	logic [PIDX_W-1:0] port_idx;
	logic              wr; // Write, first cycle only.
	logic              rd; // Read, first cycle only.

	assign region = region_e'(addr_i[ADDR_W-1 -: 2]); // Top two bits.
	assign port_idx = addr_i[PORT_IDX_BIT +: PIDX_W];

	// Request is still held in the done cycle. Strobe only once.
	assign wr = we_i & ~done_o;
	assign rd = re_i & ~done_o;

	assign ram_m.we = wr && (region == REG_RAM);
	assign ram_m.re = rd && (region == REG_RAM);
	assign ram_m.sel = sel_i;
	assign ram_m.addr = addr_i;
	assign ram_m.wdata = wdata_i;

	assign timer_m.we = wr && (region == REG_TIMER);
	assign timer_m.re = rd && (region == REG_TIMER);
	assign timer_m.sel = sel_i;
	assign timer_m.addr = addr_i;
	assign timer_m.wdata = wdata_i;

	assign hostif_m.we = wr && (region == REG_HOSTIF);
	assign hostif_m.re = rd && (region == REG_HOSTIF);
	assign hostif_m.sel = sel_i;
	assign hostif_m.addr = addr_i;
	assign hostif_m.wdata = wdata_i;

	// Port strobes also need the index match.
	for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
		assign ports_m[i].we = wr && (region == REG_PORTS) && (port_idx == PIDX_W'(i));
		assign ports_m[i].re = rd && (region == REG_PORTS) && (port_idx == PIDX_W'(i));
		assign ports_m[i].sel = sel_i;
		assign ports_m[i].addr = addr_i;
		assign ports_m[i].wdata = wdata_i;
	end

	// Done one cycle after the request, one cycle long.
	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			done_o <= 1'b0;
		end else begin
			done_o <= (re_i | we_i) & ~done_o;
		end
	end

	// Held for the read mux in the done cycle.
	always_ff @(posedge usb_clk) begin
		if (re_i | we_i) begin
			region_o <= region;
			port_idx_o <= port_idx;
		end
	end

	a_no_rw: assert property (@(posedge usb_clk) disable iff (usb_rst) !(re_i && we_i));
	a_done_single: assert property (@(posedge usb_clk) disable iff (usb_rst)
		done_o |=> !done_o);

endmodule

/* hdl/softusb_rdmux.sv */
/*
 * Read-back multiplexer.
 * Picks slave or port read data from the registered region and index.
 */
`timescale 1ns/100ps

module softusb_rdmux import softusb_bus_pkg::*, softusb_port_pkg::*; #(
	parameter int NUM_PORTS = NUM_PORTS_DEF,
	localparam int PIDX_W = idx_w(NUM_PORTS)
) (
	input  region_e           region_i,
	input  logic [PIDX_W-1:0] port_idx_i,
	output logic [DATA_W-1:0] rdata_o,
	softusb_mem_if.monitor    ram_s,
	softusb_mem_if.monitor    timer_s,
	softusb_mem_if.monitor    hostif_s,
	softusb_mem_if.monitor    ports_s [NUM_PORTS]
);

	logic [DATA_W-1:0] port_rdata [NUM_PORTS]; // Flattened for a run-time index.

	for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
		assign port_rdata[i] = ports_s[i].rdata;
	end

	always_comb begin
		case (region_i)
			REG_RAM:    rdata_o = ram_s.rdata;
			REG_TIMER:  rdata_o = timer_s.rdata;
			REG_HOSTIF: rdata_o = hostif_s.rdata;
			default:    rdata_o = port_rdata[port_idx_i]; // Port bank.
		endcase
	end

endmodule

/* hdl/softusb_ram.sv */
/*
 * Program/data RAM.
 * Single port, byte-enabled writes, registered read.
 */
`timescale 1ns/100ps

module softusb_ram import softusb_bus_pkg::*; #(
	parameter int RAM_WORDS = RAM_WORDS_DEF
) (
	input logic          usb_clk,
	input logic          usb_rst,
	softusb_mem_if.slave bus
);

	localparam int AW = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

	logic [DATA_W-1:0] mem [RAM_WORDS];
	logic [AW-1:0]     word_idx;
	logic [DATA_W-1:0] rdata_q;

	// Word address, wrapped to the depth.
	assign word_idx = AW'(bus.addr[ADDR_W-1:2] % RAM_WORDS);

	// Byte lanes written independently.
	always_ff @(posedge usb_clk) begin
		for (int b = 0; b < SEL_W; b++) begin
			if (bus.we && bus.sel[b]) begin
				mem[word_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
			end
		end
	end

	// Read on the request edge. Old data if written at the same edge.
	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			rdata_q <= '0;
		end else if (bus.re) begin
			rdata_q <= mem[word_idx];
		end
	end

	assign bus.rdata = rdata_q; // Valid in the done cycle.

endmodule

/* hdl/softusb_timer.sv */
/*
 * Tick timer.
 * 32-bit free-running counter, cleared by any write.
 */
`timescale 1ns/100ps

module softusb_timer import softusb_bus_pkg::*; (
	input logic          usb_clk,
	input logic          usb_rst,
	softusb_mem_if.slave bus
);

	logic [DATA_W-1:0] count;

	always_ff @(posedge usb_clk) begin
		if (usb_rst || bus.we) begin
			count <= '0; // Write data ignored.
		end else begin
			count <= count + 1'b1;
		end
	end

	assign bus.rdata = count; // Live value.

endmodule

/* hdl/softusb_hostif.sv */
/*
 * Host mailbox.
 * Outbox byte toward the host, inbox byte from the host.
 * One-cycle interrupt after each processor write.
 */
`timescale 1ns/100ps

module softusb_hostif import softusb_bus_pkg::*; (
	input  logic         usb_clk,
	input  logic         usb_rst,
	softusb_mem_if.slave bus,
	input  logic         host_we_i,
	input  logic [7:0]   host_di_i,
	output logic [7:0]   host_do_o,
	output logic         irq_o
);

	logic [7:0] inbox;

	// Outbox, low byte of the write data.
	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			host_do_o <= 8'h00;
			irq_o <= 1'b0;
		end else begin
			if (bus.we) begin
				host_do_o <= bus.wdata[7:0];
			end
			irq_o <= bus.we; // Pulse follows the write edge.
		end
	end

	// Inbox, loaded by the host.
	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			inbox <= 8'h00;
		end else if (host_we_i) begin
			inbox <= host_di_i;
		end
	end

	assign bus.rdata = {{(DATA_W-16){1'b0}}, host_do_o, inbox};

	// Write strobe is one cycle per access, so no stretched pulse.
	a_irq_pulse: assert property (@(posedge usb_clk) disable iff (usb_rst)
		irq_o |=> !irq_o);

endmodule

/* port/softusb_port.sv */
/*
 * One USB port.
 * Control register, transmit line-state driver.
 * Two-stage receive synchronizer, sticky line-change flag.
 * Register read-back selected by port register.
 */
`timescale 1ns/100ps

module softusb_port import softusb_bus_pkg::*, softusb_port_pkg::*; (
	input  logic         usb_clk,
	input  logic         usb_rst,
	softusb_mem_if.slave bus,
	output logic         spd_o,
	output logic         oe_n_o,
	output logic         vp_o,
	output logic         vm_o,
	input  logic         vp_i,
	input  logic         vm_i,
	input  logic         rcv_i
);

	port_reg_e         preg;
	logic              oe;        // Output enable, active high.
	line_e             tx_line;   // Driven line state.
	logic [2:0]        rx_meta;   // First sync stage.
	logic [2:0]        rx_sync;   // {rcv, vm, vp}, synchronized.
	logic [1:0]        line_prev; // Last cycle's vm/vp.
	logic              change;
	logic              event_q;
	logic [DATA_W-1:0] rdata_q;

	assign preg = port_reg_e'(bus.addr[3:2]);

	// Control and transmit registers.
	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			spd_o <= 1'b0;
			oe <= 1'b0;
			tx_line <= LS_SE0;
		end else if (bus.we) begin
			if (preg == PR_CTRL) begin
				spd_o <= bus.wdata[0];
				oe <= bus.wdata[1];
			end else if (preg == PR_TX) begin
				tx_line <= line_e'(bus.wdata[1:0]);
			end
		end
	end

	assign oe_n_o = ~oe;

	// Line state to pad levels.
	always_comb begin
		case (tx_line)
			LS_J:    {vm_o, vp_o} = 2'b01;
			LS_K:    {vm_o, vp_o} = 2'b10;
			LS_SE1:  {vm_o, vp_o} = 2'b11;
			default: {vm_o, vp_o} = 2'b00; // SE0.
		endcase
	end

	// Two flops from the pads.
	always_ff @(posedge usb_clk) begin
		rx_meta <= {rcv_i, vm_i, vp_i};
		rx_sync <= rx_meta;
		line_prev <= rx_sync[1:0];
	end

	assign change = (rx_sync[1:0] != line_prev); // Line state only, not rcv.

	// Sticky flag. A new change beats the read clear.
	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			event_q <= 1'b0;
		end else if (change) begin
			event_q <= 1'b1;
		end else if (bus.re && preg == PR_EVENT) begin
			event_q <= 1'b0;
		end
	end

	// Captured on the request edge, before the flag clears.
	always_ff @(posedge usb_clk) begin
		if (bus.re) begin
			case (preg)
				PR_CTRL:  rdata_q <= {{(DATA_W-2){1'b0}}, oe, spd_o};
				PR_TX:    rdata_q <= {{(DATA_W-2){1'b0}}, tx_line};
				PR_RX:    rdata_q <= {{(DATA_W-3){1'b0}}, rx_sync};
				default:  rdata_q <= {{(DATA_W-1){1'b0}}, event_q};
			endcase
		end
	end

	assign bus.rdata = rdata_q;

	// SE1 never goes out on an enabled driver.
	a_no_se1_drive: assert property (@(posedge usb_clk) disable iff (usb_rst)
		!oe_n_o |-> (tx_line != LS_SE1));

endmodule

/* hdl/softusb_top.sv */
/*
 * USB controller peripheral top level.
 * Decoder, RAM, timer, host mailbox, port bank and read mux.
 */
`timescale 1ns/100ps

module softusb_top import softusb_bus_pkg::*, softusb_port_pkg::*; #(
	parameter int RAM_WORDS = RAM_WORDS_DEF,
	parameter int NUM_PORTS = NUM_PORTS_DEF,
	localparam int PIDX_W = idx_w(NUM_PORTS)
) (
	input  logic                 usb_clk,
	input  logic                 usb_rst,
	input  logic                 mem_re_i,
	input  logic                 mem_we_i,
	input  logic [ADDR_W-1:0]    mem_addr_i,
	input  logic [SEL_W-1:0]     mem_sel_i,
	input  logic [DATA_W-1:0]    mem_wdata_i,
	output logic                 mem_done_o,
	output logic [DATA_W-1:0]    mem_rdata_o,
	input  logic                 host_we_i,
	input  logic [7:0]           host_di_i,
	output logic [7:0]           host_do_o,
	output logic                 irq_o,
	output logic [NUM_PORTS-1:0] spd_o,
	output logic [NUM_PORTS-1:0] oe_n_o,
	output logic [NUM_PORTS-1:0] vp_o,
	output logic [NUM_PORTS-1:0] vm_o,
	input  logic [NUM_PORTS-1:0] vp_i,
	input  logic [NUM_PORTS-1:0] vm_i,
	input  logic [NUM_PORTS-1:0] rcv_i
);

	region_e           region_q; // Region of the access in flight.
	logic [PIDX_W-1:0] port_idx_q;

	softusb_mem_if ram_bus ();
	softusb_mem_if timer_bus ();
	softusb_mem_if hostif_bus ();
	softusb_mem_if port_bus [NUM_PORTS] ();

	softusb_decoder #(.NUM_PORTS(NUM_PORTS)) u_decoder (
		.usb_clk(usb_clk), .usb_rst(usb_rst),
		.re_i(mem_re_i), .we_i(mem_we_i), .addr_i(mem_addr_i),
		.sel_i(mem_sel_i), .wdata_i(mem_wdata_i),
		.done_o(mem_done_o), .region_o(region_q), .port_idx_o(port_idx_q),
		.ram_m(ram_bus), .timer_m(timer_bus), .hostif_m(hostif_bus), .ports_m(port_bus)
	);

	softusb_ram #(.RAM_WORDS(RAM_WORDS)) u_ram (
		.usb_clk(usb_clk), .usb_rst(usb_rst), .bus(ram_bus)
	);

	softusb_timer u_timer (.usb_clk(usb_clk), .usb_rst(usb_rst), .bus(timer_bus));

	softusb_hostif u_hostif (
		.usb_clk(usb_clk), .usb_rst(usb_rst), .bus(hostif_bus),
		.host_we_i(host_we_i), .host_di_i(host_di_i),
		.host_do_o(host_do_o), .irq_o(irq_o)
	);

	// One line interface per port.
	for (genvar g = 0; g < NUM_PORTS; g++) begin : g_port
		softusb_port u_port (
			.usb_clk(usb_clk), .usb_rst(usb_rst), .bus(port_bus[g]),
			.spd_o(spd_o[g]), .oe_n_o(oe_n_o[g]), .vp_o(vp_o[g]), .vm_o(vm_o[g]),
			.vp_i(vp_i[g]), .vm_i(vm_i[g]), .rcv_i(rcv_i[g])
		);
	end

	softusb_rdmux #(.NUM_PORTS(NUM_PORTS)) u_rdmux (
		.region_i(region_q), .port_idx_i(port_idx_q), .rdata_o(mem_rdata_o),
		.ram_s(ram_bus), .timer_s(timer_bus), .hostif_s(hostif_bus), .ports_s(port_bus)
	);

endmodule

/* sim/tb_softusb.sv */
/*
 * Testbench for the USB controller peripheral top level.
 * Bus master tasks, value check, watchdog and a USB line model.
 * Directed tests for reset, RAM, timer, host mailbox and the port bank.
 */
`timescale 1ns/100ps

module tb_softusb
	import softusb_bus_pkg::*, softusb_port_pkg::*;
();

	localparam int NP = NUM_PORTS_DEF;
	// About 80 accesses of 4 cycles plus waits. Wide margin.
	localparam int WATCHDOG_CYCLES = 5000;
	localparam logic [ADDR_W-1:0] RAM_BASE = {REG_RAM, 30'h0};
	localparam logic [ADDR_W-1:0] TIMER_BASE = {REG_TIMER, 30'h0};
	localparam logic [ADDR_W-1:0] HOSTIF_BASE = {REG_HOSTIF, 30'h0};

	logic              usb_clk;
	logic              usb_rst;
	logic              mem_re;
	logic              mem_we;
	logic [ADDR_W-1:0] mem_addr;
	logic [SEL_W-1:0]  mem_sel;
	logic [DATA_W-1:0] mem_wdata;
	logic              mem_done;
	logic [DATA_W-1:0] mem_rdata;
	logic              host_we;
	logic [7:0]        host_di;
	logic [7:0]        host_do;
	logic              irq;
	logic [NP-1:0]     spd;
	logic [NP-1:0]     oe_n;
	logic [NP-1:0]     vp_o;
	logic [NP-1:0]     vm_o;
	logic [NP-1:0]     vp_i = '0; // Line model outputs.
	logic [NP-1:0]     vm_i = '0;
	logic [NP-1:0]     rcv_i = '0;
	logic [NP-1:0]     drv_vp; // Far-end levels chosen by the tests.
	logic [NP-1:0]     drv_vm;
	logic [NP-1:0]     drv_rcv;
	int                errors = 0;
	int                irq_count = 0; // Cycles with irq high.

	softusb_top u_softusb_top (
		.usb_clk(usb_clk), .usb_rst(usb_rst),
		.mem_re_i(mem_re), .mem_we_i(mem_we), .mem_addr_i(mem_addr),
		.mem_sel_i(mem_sel), .mem_wdata_i(mem_wdata),
		.mem_done_o(mem_done), .mem_rdata_o(mem_rdata),
		.host_we_i(host_we), .host_di_i(host_di), .host_do_o(host_do), .irq_o(irq),
		.spd_o(spd), .oe_n_o(oe_n), .vp_o(vp_o), .vm_o(vm_o),
		.vp_i(vp_i), .vm_i(vm_i), .rcv_i(rcv_i)
	);

	initial begin
		usb_clk = 1'b0;
		forever #10 usb_clk = ~usb_clk; // 20 ns period.
	end

	// Line model. Loopback while driving, one cycle of wire delay.
	always @(posedge usb_clk) begin
		for (int p = 0; p < NP; p++) begin
			vp_i[p] <= oe_n[p] ? drv_vp[p] : vp_o[p];
			vm_i[p] <= oe_n[p] ? drv_vm[p] : vm_o[p];
			rcv_i[p] <= drv_rcv[p]; // Receiver always from the far end.
		end
	end

	always @(negedge usb_clk) begin
		if (irq) irq_count++;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge usb_clk);
		$display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		fail_run();
	end

	task automatic fail_run();
		$display("** FAIL **");
		$fatal(1, "Stopped at the first failure.");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Error: %s is %h, expected %h", name, got, exp);
			fail_run();
		end
	endtask

	// One bus access. Done must come in the cycle after the request.
	task automatic access(input logic wr, input logic [31:0] addr, input logic [3:0] sel,
			input logic [31:0] wdata, output logic [31:0] rdata);
		int waited;
		waited = 0;
		@(posedge usb_clk);
		mem_re <= ~wr;
		mem_we <= wr;
		mem_addr <= addr;
		mem_sel <= sel;
		mem_wdata <= wdata;
		do begin
			@(negedge usb_clk);
			waited++;
			if (waited > 16) begin
				$display("Access to address %h was never acknowledged", addr);
				fail_run();
			end
		end while (!mem_done);
		rdata = mem_rdata; // Valid in the done cycle.
		check("mem_done_o latency", 32'(waited - 1), 32'd1);
		@(posedge usb_clk);
		mem_re <= 1'b0; // Dropped in the done cycle.
		mem_we <= 1'b0;
		@(negedge usb_clk);
		check("mem_done_o", 32'(mem_done), 32'd0); // Single-cycle acknowledge.
	endtask

	task automatic bus_write(input logic [31:0] addr, input logic [3:0] sel,
			input logic [31:0] data);
		logic [31:0] unused;
		access(1'b1, addr, sel, data, unused);
	endtask

	task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
		access(1'b0, addr, 4'hF, 32'h0, data);
	endtask

	function automatic logic [31:0] port_addr(input int p, input port_reg_e r);
		return {REG_PORTS, 30'h0} | (32'(p) << PORT_IDX_BIT) | {28'h0, r, 2'b00};
	endfunction

	// Byte-enable rule. Only selected lanes take new data.
	function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
			input logic [31:0] new_w, input logic [3:0] sel);
		logic [31:0] res;
		res = old_w;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) res[8*b +: 8] = new_w[8*b +: 8];
		end
		return res;
	endfunction

	task automatic reset_ack_test();
		logic [31:0] rd;
		@(negedge usb_clk);
		check("mem_done_o", 32'(mem_done), 32'd0);
		check("irq_o", 32'(irq), 32'd0);
		check("spd_o", 32'(spd), 32'd0);
		check("oe_n_o", 32'(oe_n), 32'({NP{1'b1}})); // All drivers off.
		check("vp_o", 32'(vp_o), 32'd0);
		check("vm_o", 32'(vm_o), 32'd0);
		check("host_do_o", 32'(host_do), 32'd0);
		bus_read(HOSTIF_BASE, rd);
		check("mem_rdata_o mailbox", rd, 32'd0); // Both boxes empty.
		bus_read(port_addr(0, PR_EVENT), rd);
		check("mem_rdata_o port 0 event", rd, 32'd0);
		bus_write(RAM_BASE, 4'hF, 32'h0);
		bus_read(TIMER_BASE, rd);
	endtask

	task automatic ram_test();
		logic [31:0] addrs [8];
		logic [31:0] model [RAM_WORDS_DEF]; // Testbench copy of the RAM.
		logic [31:0] data;
		logic [31:0] rd;
		logic [3:0]  sel;
		int          idx;
		for (int i = 0; i < 8; i++) begin // Full words first.
			addrs[i] = {REG_RAM, 30'($urandom())};
			data = $urandom();
			idx = int'((addrs[i] >> 2) % RAM_WORDS_DEF); // Wraps at the depth.
			model[idx] = data;
			bus_write(addrs[i], 4'hF, data);
		end
		for (int i = 0; i < 8; i++) begin // Then partial writes.
			data = $urandom();
			sel = 4'($urandom_range(14, 1));
			idx = int'((addrs[i] >> 2) % RAM_WORDS_DEF);
			model[idx] = merge_bytes(model[idx], data, sel);
			bus_write(addrs[i], sel, data);
		end
		for (int i = 0; i < 8; i++) begin
			idx = int'((addrs[i] >> 2) % RAM_WORDS_DEF);
			bus_read(addrs[i], rd);
			check($sformatf("mem_rdata_o ram[%0d]", idx), rd, model[idx]);
		end
	endtask

	task automatic timer_test();
		logic [31:0] t0;
		logic [31:0] t1;
		int          gap;
		for (int n = 0; n < 3; n++) begin
			gap = int'($urandom_range(20, 1));
			bus_write(TIMER_BASE, 4'hF, $urandom()); // Any write clears.
			repeat (gap) @(posedge usb_clk);
			bus_read(TIMER_BASE, t0);
			if (t0 < 32'(gap + 1) || t0 >= 32'(gap + 10)) begin
				$display("Timer read %0d cycles after a clear gave %h, out of range", gap, t0);
				fail_run();
			end
			bus_read(TIMER_BASE, t1);
			if (t1 <= t0) begin
				$display("Timer did not advance between reads: %h then %h", t0, t1);
				fail_run();
			end
		end
	endtask

	task automatic mailbox_test();
		logic [7:0]  out_b;
		logic [7:0]  in_b;
		logic [31:0] rd;
		int          irq_before;
		out_b = 8'($urandom());
		in_b = 8'($urandom());
		irq_before = irq_count;
		bus_write(HOSTIF_BASE, 4'hF, {24'($urandom()), out_b}); // Upper bytes ignored.
		repeat (3) @(posedge usb_clk);
		check("host_do_o", 32'(host_do), 32'(out_b));
		check("irq_o pulse cycles", 32'(irq_count - irq_before), 32'd1);
		@(posedge usb_clk);
		host_we <= 1'b1;
		host_di <= in_b;
		@(posedge usb_clk);
		host_we <= 1'b0;
		bus_read(HOSTIF_BASE, rd);
		check("mem_rdata_o mailbox", rd, {16'h0, out_b, in_b});
		check("irq_o pulse cycles", 32'(irq_count - irq_before), 32'd1); // No extra irq.
	endtask

	task automatic port_line_test();
		logic [3:0] other_before;
		line_e      ls;
		logic [1:0] exp_lines; // {vm, vp}.
		int         q;
		for (int p = 0; p < NP; p++) begin
			q = (p + 1) % NP;
			other_before = {spd[q], oe_n[q], vp_o[q], vm_o[q]};
			bus_write(port_addr(p, PR_CTRL), 4'hF, 32'h1); // Full speed, driver off.
			@(negedge usb_clk);
			check($sformatf("spd_o[%0d]", p), 32'(spd[p]), 32'd1);
			check($sformatf("oe_n_o[%0d]", p), 32'(oe_n[p]), 32'd1);
			bus_write(port_addr(p, PR_CTRL), 4'hF, 32'h0);
			for (int k = 0; k < 4; k++) begin
				ls = line_e'(k[1:0]);
				case (ls)
					LS_J:    exp_lines = 2'b01;
					LS_K:    exp_lines = 2'b10;
					LS_SE1:  exp_lines = 2'b11;
					default: exp_lines = 2'b00;
				endcase
				bus_write(port_addr(p, PR_TX), 4'hF, 32'(k));
				@(negedge usb_clk);
				check($sformatf("vp_o[%0d]", p), 32'(vp_o[p]), 32'(exp_lines[0]));
				check($sformatf("vm_o[%0d]", p), 32'(vm_o[p]), 32'(exp_lines[1]));
			end
			bus_write(port_addr(p, PR_TX), 4'hF, 32'(LS_J)); // Idle J before driving.
			bus_write(port_addr(p, PR_CTRL), 4'hF, 32'h2);
			@(negedge usb_clk);
			check($sformatf("oe_n_o[%0d]", p), 32'(oe_n[p]), 32'd0);
			check($sformatf("spd_o[%0d]", p), 32'(spd[p]), 32'd0);
			if (NP > 1) begin
				check($sformatf("port %0d lines", q), 32'({spd[q], oe_n[q], vp_o[q], vm_o[q]}),
					32'(other_before));
			end
		end
	endtask

	task automatic port_rx_test();
		logic [31:0] rd;
		logic [2:0]  lines; // {rcv, vm, vp}.
		for (int p = 0; p < NP; p++) begin
			bus_write(port_addr(p, PR_CTRL), 4'hF, 32'h0); // Far end drives.
			@(posedge usb_clk);
			drv_vp[p] <= 1'b0;
			drv_vm[p] <= 1'b0;
			drv_rcv[p] <= 1'b0;
			repeat (6) @(posedge usb_clk);
			bus_read(port_addr(p, PR_EVENT), rd); // Drop the flag from the switch-over.
			lines = {1'($urandom()), 2'($urandom_range(3, 1))}; // Differs from SE0.
			@(posedge usb_clk);
			drv_vp[p] <= lines[0];
			drv_vm[p] <= lines[1];
			drv_rcv[p] <= lines[2];
			repeat (4) @(posedge usb_clk); // Three sync edges plus the model delay.
			bus_read(port_addr(p, PR_RX), rd);
			check($sformatf("port %0d rx", p), rd, 32'(lines));
			bus_read(port_addr(p, PR_EVENT), rd);
			check($sformatf("port %0d event", p), rd, 32'd1);
			bus_read(port_addr(p, PR_EVENT), rd);
			check($sformatf("port %0d event after read", p), rd, 32'd0);
		end
	endtask

	initial begin
		void'($urandom(32'h8e17));
		mem_re <= 1'b0;
		mem_we <= 1'b0;
		mem_addr <= '0;
		mem_sel <= '0;
		mem_wdata <= '0;
		host_we <= 1'b0;
		host_di <= 8'h00;
		drv_vp <= '0;
		drv_vm <= '0;
		drv_rcv <= '0;
		usb_rst <= 1'b1;
		repeat (3) @(posedge usb_clk);
		usb_rst <= 1'b0;
		reset_ack_test();
		ram_test();
		timer_test();
		mailbox_test();
		port_line_test();
		port_rx_test();
		if (errors == 0) begin
			$display("** PASS **");
			$finish;
		end else begin
			fail_run();
		end
	end

endmodule

/* softusb.f */
common/softusb_bus_pkg.sv
common/softusb_port_pkg.sv
common/softusb_mem_if.sv
hdl/softusb_decoder.sv
hdl/softusb_rdmux.sv
hdl/softusb_ram.sv
hdl/softusb_timer.sv
hdl/softusb_hostif.sv
port/softusb_port.sv
hdl/softusb_top.sv
sim/tb_softusb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_softusb
FILELIST = softusb.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

# Build and run; the status comes from the pass line in the output.
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q -F '** PASS **'

clean:
	rm -rf $(OBJ_DIR)
